// ==== hdl/wb_macros.svh ====
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// 6-bit exception codes
`define ECODE_INT    6'h00
`define ECODE_ADEF   6'h08
`define ECODE_ALE    6'h09
`define ECODE_SYS    6'h0B
`define ECODE_BRK    6'h0C
`define ECODE_INE    6'h0D

// 14-bit csr numbers
`define CSR_CRMD     14'h0000
`define CSR_PRMD     14'h0001
`define CSR_ESTAT    14'h0005
`define CSR_ERA      14'h0006
`define CSR_BADV     14'h0007
`define CSR_EENTRY   14'h000C
`define CSR_SAVE0    14'h0030

// crmd resets with only DA set
`define CRMD_RESET   32'h0000_0008

// field positions used on exception entry and return
`define CRMD_PLV_IE  2:0
`define ESTAT_ECODE  21:16

`endif

// ==== hdl/wb_pkg.sv ====
package wb_pkg;

    // the aux word means a write mask or a faulting address,
    // depending on whether the item carries an ale fault
    typedef union packed {
        logic [31:0] csr_wmask;
        logic [31:0] bad_vaddr;
    } aux_word_u;

    typedef struct packed {
        logic has_int;
        logic adef;
        logic ine;
        logic sys;
        logic brk;
        logic ale;
    } excp_flags_t;

    // one instruction item from the memory stage
    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_result;
        logic        res_from_csr;
        logic [13:0] csr_num;
        logic        csr_we;
        logic [31:0] csr_wvalue;
        aux_word_u   aux;
        logic        ertn;
        excp_flags_t flags;
    } mem_to_wb_t;

    // resolved trap record qualified by wb_valid
    typedef struct packed {
        logic        excep;
        logic        ertn;
        logic [5:0]  ecode;
        logic        badv_we;
        logic [31:0] badv;
    } trap_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

// ==== hdl/wb_stage_reg.sv ====
module wb_stage_reg (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  wb_pkg::mem_to_wb_t in_item,
    output logic               wb_valid,
    output wb_pkg::mem_to_wb_t wb_item
);

    logic               valid_q;
    wb_pkg::mem_to_wb_t item_q;

    // stage is always ready so valid simply follows the strobe
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // a bubble keeps the old payload
    always_ff @(posedge clk) begin
        if (in_valid) begin
            item_q <= in_item;
        end
    end

    assign wb_valid = valid_q;
    assign wb_item  = item_q;

endmodule

// ==== hdl/wb_excp_resolver.sv ====
`include "wb_macros.svh"

module wb_excp_resolver (
    input  logic               wb_valid,
    input  wb_pkg::mem_to_wb_t wb_item,
    output wb_pkg::trap_t      trap
);

    wb_pkg::excp_flags_t flags;
    logic                any_excp;
    logic                ale_cause;
    logic [5:0]          ecode;

    assign flags    = wb_item.flags;
    assign any_excp = |flags;

    // ale has the lowest priority, so it is the cause only when alone
    assign ale_cause = flags.ale & ~(flags.has_int | flags.adef | flags.ine |
                                     flags.sys | flags.brk);

    // fixed priority order is int, adef, ine, sys, brk, ale
    always_comb begin
        if (flags.has_int) begin
            ecode = `ECODE_INT;
        end else if (flags.adef) begin
            ecode = `ECODE_ADEF;
        end else if (flags.ine) begin
            ecode = `ECODE_INE;
        end else if (flags.sys) begin
            ecode = `ECODE_SYS;
        end else if (flags.brk) begin
            ecode = `ECODE_BRK;
        end else if (flags.ale) begin
            ecode = `ECODE_ALE;
        end else begin
            ecode = 6'h00;
        end
    end

    always_comb begin
        trap         = '0;
        trap.excep   = wb_valid & any_excp;
        trap.ertn    = wb_valid & wb_item.ertn & ~any_excp;
        trap.ecode   = wb_valid ? ecode : 6'h00;
        trap.badv_we = wb_valid & ale_cause;
        // aux word holds the faulting address here
        trap.badv    = wb_item.aux.bad_vaddr;
    end

endmodule

// ==== hdl/wb_csr_file.sv ====
`include "wb_macros.svh"

module wb_csr_file (
    input  logic               clk,
    input  logic               resetn,
    input  logic               wb_valid,
    input  wb_pkg::mem_to_wb_t wb_item,
    input  wb_pkg::trap_t      trap,
    output logic [31:0]        csr_rvalue,
    output logic [31:0]        ex_entry,
    output logic [31:0]        era
);

    logic [31:0] csr_crmd;
    logic [31:0] csr_prmd;
    logic [31:0] csr_estat;
    logic [31:0] csr_era;
    logic [31:0] csr_badv;
    logic [31:0] csr_eentry;
    logic [31:0] csr_save0;

    logic        csr_wr_en;
    logic [31:0] wr_mask;
    logic [31:0] wr_merged;

    // read port gives zero for unknown numbers
    always_comb begin
        case (wb_item.csr_num)
            `CSR_CRMD: begin
                csr_rvalue = csr_crmd;
            end
            `CSR_PRMD: begin
                csr_rvalue = csr_prmd;
            end
            `CSR_ESTAT: begin
                csr_rvalue = csr_estat;
            end
            `CSR_ERA: begin
                csr_rvalue = csr_era;
            end
            `CSR_BADV: begin
                csr_rvalue = csr_badv;
            end
            `CSR_EENTRY: begin
                csr_rvalue = csr_eentry;
            end
            `CSR_SAVE0: begin
                csr_rvalue = csr_save0;
            end
            default: begin
                csr_rvalue = 32'h0000_0000;
            end
        endcase
    end

    // a trapping item never writes
    assign csr_wr_en = wb_valid & wb_item.csr_we & ~trap.excep & ~trap.ertn;

    // aux word is the write mask for a non-faulting item
    assign wr_mask = wb_item.aux.csr_wmask;

    // read value is the old contents of the addressed csr
    assign wr_merged = (csr_rvalue & ~wr_mask) | (wb_item.csr_wvalue & wr_mask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            csr_crmd   <= `CRMD_RESET;
            csr_prmd   <= 32'h0000_0000;
            csr_estat  <= 32'h0000_0000;
            csr_era    <= 32'h0000_0000;
            csr_badv   <= 32'h0000_0000;
            csr_eentry <= 32'h0000_0000;
            csr_save0  <= 32'h0000_0000;
        end else if (trap.excep) begin
            // exception entry saves plv/ie and drops to kernel with ints off
            csr_prmd[`CRMD_PLV_IE]   <= csr_crmd[`CRMD_PLV_IE];
            csr_crmd[`CRMD_PLV_IE]   <= 3'b000;
            csr_era                  <= wb_item.pc;
            csr_estat[`ESTAT_ECODE]  <= trap.ecode;
            if (trap.badv_we) begin
                csr_badv <= trap.badv;
            end
        end else if (trap.ertn) begin
            csr_crmd[`CRMD_PLV_IE] <= csr_prmd[`CRMD_PLV_IE];
        end else if (csr_wr_en) begin
            case (wb_item.csr_num)
                `CSR_CRMD: begin
                    csr_crmd <= wr_merged;
                end
                `CSR_PRMD: begin
                    csr_prmd <= wr_merged;
                end
                `CSR_ESTAT: begin
                    csr_estat <= wr_merged;
                end
                `CSR_ERA: begin
                    csr_era <= wr_merged;
                end
                `CSR_BADV: begin
                    csr_badv <= wr_merged;
                end
                `CSR_EENTRY: begin
                    csr_eentry <= wr_merged;
                end
                `CSR_SAVE0: begin
                    csr_save0 <= wr_merged;
                end
                default: begin
                end
            endcase
        end
    end

    assign ex_entry = csr_eentry;
    assign era      = csr_era;

endmodule

// ==== hdl/wb_commit.sv ====
module wb_commit (
    input  logic               wb_valid,
    input  wb_pkg::mem_to_wb_t wb_item,
    input  wb_pkg::trap_t      trap,
    input  logic [31:0]        csr_rvalue,
    input  logic [31:0]        ex_entry,
    input  logic [31:0]        era,
    output wb_pkg::rf_wr_t     rf_wr,
    output wb_pkg::redirect_t  redirect,
    output logic [31:0]        debug_pc
);

    logic flush;
    logic [31:0] wdata;

    // trap record is already qualified by wb_valid
    assign flush = trap.excep | trap.ertn;

    // csr reads return the csr value instead of the alu result
    assign wdata = wb_item.res_from_csr ? csr_rvalue : wb_item.rf_result;

    always_comb begin
        rf_wr.we    = wb_valid & wb_item.rf_we & ~flush;
        rf_wr.waddr = wb_item.rf_waddr;
        rf_wr.wdata = wdata;
    end

    // exception goes to eentry, ertn back to era
    always_comb begin
        redirect.valid  = flush;
        redirect.target = trap.excep ? ex_entry : era;
    end

    assign debug_pc = wb_item.pc;

endmodule

// ==== hdl/wb_commit_top.sv ====
module wb_commit_top (
    input  logic               clk,
    input  logic               resetn,
    input  logic               in_valid,
    input  wb_pkg::mem_to_wb_t in_item,
    output wb_pkg::rf_wr_t     rf_wr,
    output wb_pkg::redirect_t  redirect,
    output logic [31:0]        debug_pc
);

    logic               wb_valid;
    wb_pkg::mem_to_wb_t wb_item;
    wb_pkg::trap_t      trap;
    logic [31:0]        csr_rvalue;
    logic [31:0]        ex_entry;
    logic [31:0]        era;

    wb_stage_reg u_stage_reg (
        .clk      (clk),
        .resetn   (resetn),
        .in_valid (in_valid),
        .in_item  (in_item),
        .wb_valid (wb_valid),
        .wb_item  (wb_item)
    );

    wb_excp_resolver u_excp_resolver (
        .wb_valid (wb_valid),
        .wb_item  (wb_item),
        .trap     (trap)
    );

    // csr state updates at the next edge from the same trap record
    wb_csr_file u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .wb_valid   (wb_valid),
        .wb_item    (wb_item),
        .trap       (trap),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .era        (era)
    );

    wb_commit u_commit (
        .wb_valid   (wb_valid),
        .wb_item    (wb_item),
        .trap       (trap),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .era        (era),
        .rf_wr      (rf_wr),
        .redirect   (redirect),
        .debug_pc   (debug_pc)
    );

endmodule

// ==== verif/wb_commit_checker.sv ====
module wb_commit_checker (
    input logic              clk,
    input logic              resetn,
    input logic              in_valid,
    input wb_pkg::rf_wr_t    rf_wr,
    input wb_pkg::redirect_t redirect
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned assert_fails = 0;

    // a flush squashes the register write
    property p_no_write_on_flush;
        @(posedge clk) disable iff (!resetn)
            !(rf_wr.we && redirect.valid);
    endproperty

    // first cycle out of reset shows an empty stage
    property p_idle_after_reset;
        @(posedge clk)
            $rose(resetn) |-> (!rf_wr.we && !redirect.valid);
    endproperty

    // one cycle of latency from the input strobe
    property p_redirect_needs_input;
        @(posedge clk) disable iff (!resetn)
            redirect.valid |-> $past(in_valid);
    endproperty

    a_no_write_on_flush: assert property (p_no_write_on_flush)
        else begin
            assert_fails++;
            $error("register write and redirect are high in the same cycle");
        end

    a_idle_after_reset: assert property (p_idle_after_reset)
        else begin
            assert_fails++;
            $error("outputs not idle in the first cycle after reset release");
        end

    a_redirect_needs_input: assert property (p_redirect_needs_input)
        else begin
            assert_fails++;
            $error("redirect raised without an accepted item one cycle earlier");
        end

endmodule

bind wb_commit_top wb_commit_checker i_checker (
    .clk      (clk),
    .resetn   (resetn),
    .in_valid (in_valid),
    .rf_wr    (rf_wr),
    .redirect (redirect)
);

// ==== verif/tb_wb_commit.sv ====
`include "wb_macros.svh"

module tb_wb_commit;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic               valid;
        wb_pkg::mem_to_wb_t item;
        wb_pkg::rf_wr_t     exp_rf;
        wb_pkg::redirect_t  exp_redir;
        logic               rd_csr;
        logic [31:0]        exp_word;
    } row_t;

    localparam int RANDOM_ROWS  = 40;
    localparam int IDLE_TIMEOUT = 10;

    // flag bits in order has_int, adef, ine, sys, brk, ale
    localparam logic [5:0] FLAG_NONE = 6'b000000;
    localparam logic [5:0] FLAG_SYS  = 6'b000100;
    localparam logic [5:0] FLAG_BRK  = 6'b000010;
    localparam logic [5:0] FLAG_ALE  = 6'b000001;

    logic               clk;
    logic               resetn;
    logic               in_valid;
    wb_pkg::mem_to_wb_t in_item;
    wb_pkg::rf_wr_t     rf_wr;
    wb_pkg::redirect_t  redirect;
    logic [31:0]        debug_pc;

    row_t        rows[$];
    int          err_rf = 0;
    int          err_redir = 0;
    int          err_word = 0;
    int          err_timeout = 0;
    int unsigned seed_ret;

    wb_commit_top i_dut (
        .clk      (clk),
        .resetn   (resetn),
        .in_valid (in_valid),
        .in_item  (in_item),
        .rf_wr    (rf_wr),
        .redirect (redirect),
        .debug_pc (debug_pc)
    );

    always #10 clk = ~clk;

    function automatic wb_pkg::mem_to_wb_t alu_op(input logic [31:0] pc, input logic [4:0] rd,
                                                  input logic [31:0] result);
        wb_pkg::mem_to_wb_t it;
        it = '0;
        it.pc        = pc;
        it.rf_we     = 1'b1;
        it.rf_waddr  = rd;
        it.rf_result = result;
        return it;
    endfunction

    // rd of zero means the item writes no register
    function automatic wb_pkg::mem_to_wb_t csr_op(input logic [31:0] pc, input logic [4:0] rd,
                                                  input logic [13:0] num, input logic we,
                                                  input logic [31:0] wvalue,
                                                  input logic [31:0] wmask);
        wb_pkg::mem_to_wb_t it;
        it = '0;
        it.pc            = pc;
        it.rf_we         = (rd != 5'd0);
        it.rf_waddr      = rd;
        it.res_from_csr  = 1'b1;
        it.csr_num       = num;
        it.csr_we        = we;
        it.csr_wvalue    = wvalue;
        it.aux.csr_wmask = wmask;
        return it;
    endfunction

    // also requests a register write and a save0 clear, both must be dropped
    function automatic wb_pkg::mem_to_wb_t trap_op(input logic [31:0] pc,
                                                   input logic [5:0] flags,
                                                   input logic [31:0] aux, input logic ertn);
        wb_pkg::mem_to_wb_t it;
        it = '0;
        it.pc         = pc;
        it.rf_we      = 1'b1;
        it.rf_waddr   = 5'd9;
        it.rf_result  = 32'hdead_beef;
        it.csr_num    = `CSR_SAVE0;
        it.csr_we     = 1'b1;
        it.csr_wvalue = 32'h0000_0000;
        it.aux        = aux;
        it.ertn       = ertn;
        it.flags      = flags;
        return it;
    endfunction

    task automatic add_row(input logic valid, input wb_pkg::mem_to_wb_t item, input logic rf_we,
                           input logic [31:0] wdata, input logic redir_valid,
                           input logic [31:0] target, input logic rd_csr);
        row_t r;
        r = '0;
        r.valid            = valid;
        r.item             = item;
        r.exp_rf.we        = rf_we;
        r.exp_rf.waddr     = item.rf_waddr;
        r.exp_rf.wdata     = wdata;
        r.exp_redir.valid  = redir_valid;
        r.exp_redir.target = target;
        r.rd_csr           = rd_csr;
        r.exp_word         = wdata;
        rows.push_back(r);
    endtask

    task automatic check_rf(input wb_pkg::rf_wr_t exp, input wb_pkg::rf_wr_t act,
                            input logic with_data);
        logic bad;
        bad = (act.we !== exp.we);
        if (exp.we) begin
            bad = bad | (act.waddr !== exp.waddr);
            if (with_data) begin
                bad = bad | (act.wdata !== exp.wdata);
            end
        end
        if (bad) begin
            err_rf++;
            $display("ERR %0t rf_wr expected we=%b waddr=%0d wdata=%h actual we=%b waddr=%0d wdata=%h",
                     $time, exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
        end
    endtask

    task automatic check_redirect(input wb_pkg::redirect_t exp, input wb_pkg::redirect_t act);
        logic bad;
        bad = (act.valid !== exp.valid);
        if (exp.valid) begin
            bad = bad | (act.target !== exp.target);
        end
        if (bad) begin
            err_redir++;
            $display("ERR %0t redirect expected valid=%b target=%h actual valid=%b target=%h",
                     $time, exp.valid, exp.target, act.valid, act.target);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            err_word++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_row(input row_t r);
        check_rf(r.exp_rf, rf_wr, !r.rd_csr);
        check_redirect(r.exp_redir, redirect);
        if (r.rd_csr) begin
            check_word("rf_wr.wdata", r.exp_word, rf_wr.wdata);
        end
        if (r.valid) begin
            check_word("debug_pc", r.item.pc, debug_pc);
        end
    endtask

    // drive one row, then check the one before it, which sits in writeback now
    task automatic step(input row_t next, input row_t prev, input logic check_prev);
        @(posedge clk);
        in_valid <= next.valid;
        in_item  <= next.item;
        @(negedge clk);
        if (check_prev) begin
            check_row(prev);
        end
    endtask

    task automatic run_rows();
        row_t prev;
        row_t idle;
        prev = '0;
        idle = '0;
        foreach (rows[i]) begin
            step(rows[i], prev, i > 0);
            prev = rows[i];
        end
        step(idle, prev, rows.size() > 0);
    endtask

    task automatic wait_idle(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < IDLE_TIMEOUT) begin
            @(negedge clk);
            ok = (rf_wr.we === 1'b0) && (redirect.valid === 1'b0);
            n++;
        end
        if (!ok) begin
            err_timeout++;
            $display("timeout: outputs did not settle to idle after reset release");
        end
    endtask

    task automatic build_table();
        // alu result, then a bubble that must not write
        add_row(1'b1, alu_op(32'h1c00_0000, 5'd5, 32'h1234_5678), 1'b1, 32'h1234_5678,
                1'b0, 32'h0, 1'b0);
        add_row(1'b0, alu_op(32'h1c00_0004, 5'd6, 32'h0bad_0bad), 1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        // save0 full write, partial write returning the old value, read back
        add_row(1'b1, csr_op(32'h1c00_0008, 5'd0, `CSR_SAVE0, 1'b1, 32'hffff_0000, 32'hffff_ffff),
                1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        add_row(1'b1, csr_op(32'h1c00_000c, 5'd7, `CSR_SAVE0, 1'b1, 32'h1234_5678, 32'h0000_ffff),
                1'b1, 32'hffff_0000, 1'b0, 32'h0, 1'b1);
        add_row(1'b1, csr_op(32'h1c00_0010, 5'd8, `CSR_SAVE0, 1'b0, 32'h0, 32'h0),
                1'b1, 32'hffff_5678, 1'b0, 32'h0, 1'b1);
        // syscall goes to eentry
        add_row(1'b1, csr_op(32'h1c00_0014, 5'd0, `CSR_EENTRY, 1'b1, 32'h1c00_8000, 32'hffff_ffff),
                1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        add_row(1'b1, trap_op(32'h1c00_0100, FLAG_SYS, 32'hffff_ffff, 1'b0),
                1'b0, 32'h0, 1'b1, 32'h1c00_8000, 1'b0);
        // the stale trap item behind a bubble must not flush again
        add_row(1'b0, alu_op(32'h1c00_0104, 5'd9, 32'h0bad_0bad), 1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        add_row(1'b1, csr_op(32'h1c00_8000, 5'd10, `CSR_ESTAT, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h000b_0000, 1'b0, 32'h0, 1'b1);
        add_row(1'b1, csr_op(32'h1c00_8004, 5'd11, `CSR_ERA, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h1c00_0100, 1'b0, 32'h0, 1'b1);
        add_row(1'b1, csr_op(32'h1c00_8008, 5'd12, `CSR_SAVE0, 1'b0, 32'h0, 32'h0),
                1'b1, 32'hffff_5678, 1'b0, 32'h0, 1'b1);
        // brk wins over ale and badv stays untouched
        add_row(1'b1, trap_op(32'h1c00_0200, FLAG_BRK | FLAG_ALE, 32'h0bad_add0, 1'b0),
                1'b0, 32'h0, 1'b1, 32'h1c00_8000, 1'b0);
        add_row(1'b1, csr_op(32'h1c00_8000, 5'd13, `CSR_BADV, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h0000_0000, 1'b0, 32'h0, 1'b1);
        add_row(1'b1, csr_op(32'h1c00_8004, 5'd10, `CSR_ESTAT, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h000c_0000, 1'b0, 32'h0, 1'b1);
        // lone ale loads badv
        add_row(1'b1, trap_op(32'h1c00_0300, FLAG_ALE, 32'h1c0f_f003, 1'b0),
                1'b0, 32'h0, 1'b1, 32'h1c00_8000, 1'b0);
        add_row(1'b1, csr_op(32'h1c00_8000, 5'd13, `CSR_BADV, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h1c0f_f003, 1'b0, 32'h0, 1'b1);
        add_row(1'b1, csr_op(32'h1c00_8004, 5'd10, `CSR_ESTAT, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h0009_0000, 1'b0, 32'h0, 1'b1);
        add_row(1'b1, csr_op(32'h1c00_8008, 5'd11, `CSR_ERA, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h1c00_0300, 1'b0, 32'h0, 1'b1);
        // ertn restores plv and ie from prmd
        add_row(1'b1, csr_op(32'h1c00_800c, 5'd0, `CSR_PRMD, 1'b1, 32'h0000_0007, 32'h0000_0007),
                1'b0, 32'h0, 1'b0, 32'h0, 1'b0);
        add_row(1'b1, trap_op(32'h1c00_0400, FLAG_NONE, 32'hffff_ffff, 1'b1),
                1'b0, 32'h0, 1'b1, 32'h1c00_0300, 1'b0);
        add_row(1'b1, csr_op(32'h1c00_0300, 5'd14, `CSR_CRMD, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h0000_000f, 1'b0, 32'h0, 1'b1);
        add_row(1'b1, csr_op(32'h1c00_0304, 5'd15, `CSR_PRMD, 1'b0, 32'h0, 32'h0),
                1'b1, 32'h0000_0007, 1'b0, 32'h0, 1'b1);
        add_row(1'b1, csr_op(32'h1c00_0308, 5'd16, `CSR_SAVE0, 1'b0, 32'h0, 32'h0),
                1'b1, 32'hffff_5678, 1'b0, 32'h0, 1'b1);
    endtask

    task automatic add_random_rows(input int count);
        wb_pkg::mem_to_wb_t it;
        logic               v;
        for (int n = 0; n < count; n++) begin
            v = (($urandom % 4) != 0);
            it = alu_op($urandom & 32'hffff_fffc, 5'($urandom), $urandom);
            it.rf_we = 1'($urandom);
            // write only for a valid item that asks for one
            add_row(v, it, v & it.rf_we, it.rf_result, 1'b0, 32'h0, 1'b0);
        end
    endtask

    initial begin
        logic ok;
        clk      = 1'b0;
        resetn   = 1'b0;
        // a writing item offered during reset must leave no trace
        in_valid = 1'b1;
        in_item  = alu_op(32'h1c00_fff0, 5'd31, 32'hffff_ffff);
        seed_ret = $urandom(32'h53e03691);
        repeat (3) @(posedge clk);
        resetn   <= 1'b1;
        in_valid <= 1'b0;
        wait_idle(ok);
        if (ok) begin
            build_table();
            run_rows();
            rows.delete();
            add_random_rows(RANDOM_ROWS);
            run_rows();
        end
        $display("errors: rf=%0d redirect=%0d word=%0d timeout=%0d assert=%0d",
                 err_rf, err_redir, err_word, err_timeout, i_dut.i_checker.assert_fails);
        if (err_rf + err_redir + err_word + err_timeout + i_dut.i_checker.assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/wb_pkg.sv
hdl/wb_stage_reg.sv
hdl/wb_excp_resolver.sv
hdl/wb_csr_file.sv
hdl/wb_commit.sv
hdl/wb_commit_top.sv
verif/wb_commit_checker.sv
verif/tb_wb_commit.sv
